// ==== build.f ====
logic/spi_cmd_pkg.sv
logic/spi_cmd_if.sv
logic/spi_apb_regs.sv
logic/spi_sclk_gen.sv
logic/spi_cmd_engine.sv
logic/spi_master_top.sv
verification/spi_dev_model.sv
verification/tb_spi_master.sv

// ==== logic/spi_apb_regs.sv ====
module spi_apb_regs #(
  parameter spi_cmd_pkg::sclk_div_t DIV_RESET = 8'd4
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  spi_cmd_pkg::apb_addr_t paddr,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [31:0]            pwdata,
  output logic [31:0]            prdata,
  output logic                   pready,
  output logic                   pslverr,
  spi_cmd_if.host                cmd_bus,
  output spi_cmd_pkg::sclk_div_t div
);
  import spi_cmd_pkg::*;

  logic      wr_en;
  logic      rd_en;
  logic      cmd_wr;
  logic      cmd_accept;
  logic      cmd_vld;
  logic      busy;
  logic      rd_valid;
  logic      rdy_q;
  logic      done;
  spi_cmd_t  cmd_reg;
  spi_data_t rdata_reg;
  sclk_div_t div_reg;

  // with no wait states every access completes in its access phase
  assign pready = 1'b1;

  assign wr_en      = psel && penable && pwrite;
  assign rd_en      = psel && penable && !pwrite;
  assign cmd_wr     = wr_en && (paddr == REG_CMD);
  assign cmd_accept = cmd_wr && !busy;

  // a command written while the engine still works is dropped
  assign pslverr = cmd_wr && busy;

  // the engine raises cmd_rdy again only in its DONE cycle
  assign done = cmd_bus.rd_vld || (cmd_bus.cmd_rdy && !rdy_q);

  assign cmd_bus.cmd     = cmd_reg;
  assign cmd_bus.cmd_vld = cmd_vld;
  assign div             = div_reg;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cmd_vld   <= 1'b0;
      busy      <= 1'b0;
      rd_valid  <= 1'b0;
      rdy_q     <= 1'b1;
      rdata_reg <= '0;
      div_reg   <= DIV_RESET;
    end
    else
    begin
      rdy_q <= cmd_bus.cmd_rdy;

      if (cmd_accept)
        cmd_vld <= 1'b1;
      else if (cmd_bus.cmd_rdy)
        cmd_vld <= 1'b0;

      if (cmd_accept)
        busy <= 1'b1;
      else if (done)
        busy <= 1'b0;

      // new read data wins over a clearing read in the same cycle
      if (cmd_bus.rd_vld)
      begin
        rd_valid  <= 1'b1;
        rdata_reg <= cmd_bus.rd_data;
      end
      else if (rd_en && (paddr == REG_RDATA))
      begin
        rd_valid <= 1'b0;
      end

      if (wr_en && (paddr == REG_DIV))
        div_reg <= pwdata[7:0];
    end
  end

  always_ff @(posedge clk)
  begin
    if (cmd_accept)
      cmd_reg <= pwdata[11:0];
  end

  always_comb
  begin
    prdata = '0;
    case (paddr)
      REG_CMD:
      begin
        prdata = 32'(cmd_reg);
      end
      REG_STATUS:
      begin
        prdata = {30'd0, rd_valid, busy};
      end
      REG_RDATA:
      begin
        prdata = 32'(rdata_reg);
      end
      REG_DIV:
      begin
        prdata = 32'(div_reg);
      end
      default:
      begin
        prdata = '0;
      end
    endcase
  end

endmodule

// ==== logic/spi_cmd_engine.sv ====
module spi_cmd_engine #(
  parameter int GAP_CLKS = 16
) (
  input  logic      clk,
  input  logic      rst_n,
  spi_cmd_if.engine cmd_bus,
  input  logic      rise,
  input  logic      fall,
  output logic      run,
  output logic      cs_n,
  output logic      mosi,
  input  logic      miso
);
  import spi_cmd_pkg::*;

  localparam int GAP_W = $clog2(GAP_CLKS + 1);

  engine_state_t    state;
  spi_cmd_t         tx_shift;
  spi_data_t        rx_shift;
  logic             is_write;
  logic [3:0]       bit_cnt;
  logic [3:0]       cmd_len;
  logic [GAP_W-1:0] gap_cnt;
  logic             accept;

  // DONE also takes a command so back-to-back frames lose no cycle
  assign cmd_bus.cmd_rdy = (state == IDLE) || (state == DONE);
  assign accept          = cmd_bus.cmd_vld && cmd_bus.cmd_rdy;

  // sclk only runs while a chip-select window is open
  assign run = (state == SHIFT_CMD) || (state == SHIFT_READ);

  // a read sends only the flag and the register address
  assign cmd_len = is_write ? 4'(WRITE_BITS) : 4'(ADDR_BITS);

  assign cmd_bus.rd_data = rx_shift;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state          <= IDLE;
      cs_n           <= 1'b1;
      mosi           <= 1'b0;
      is_write       <= 1'b0;
      bit_cnt        <= '0;
      gap_cnt        <= '0;
      cmd_bus.rd_vld <= 1'b0;
    end
    else
    begin
      cmd_bus.rd_vld <= 1'b0;

      case (state)
        IDLE, DONE:
        begin
          if (accept)
          begin
            // the first bit is on mosi a full half-period before the first rise
            state    <= SHIFT_CMD;
            cs_n     <= 1'b0;
            mosi     <= cmd_bus.cmd[11];
            is_write <= cmd_bus.cmd[11];
            bit_cnt  <= '0;
          end
          else
          begin
            state <= IDLE;
          end
        end

        SHIFT_CMD:
        begin
          if (rise)
            bit_cnt <= bit_cnt + 1'b1;

          if (fall)
          begin
            if (bit_cnt == cmd_len)
            begin
              // chip select closes together with the last falling edge
              cs_n    <= 1'b1;
              mosi    <= 1'b0;
              bit_cnt <= '0;
              gap_cnt <= '0;
              state   <= is_write ? DONE : GAP;
            end
            else
            begin
              mosi <= tx_shift[11];
            end
          end
        end

        GAP:
        begin
          if (gap_cnt == GAP_W'(GAP_CLKS - 1))
          begin
            cs_n  <= 1'b0;
            state <= SHIFT_READ;
          end
          else
          begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end

        SHIFT_READ:
        begin
          if (rise)
            bit_cnt <= bit_cnt + 1'b1;

          // the last bit was sampled on the rise before this fall
          if (fall && (bit_cnt == 4'(READ_BITS)))
          begin
            cs_n           <= 1'b1;
            cmd_bus.rd_vld <= 1'b1;
            state          <= DONE;
          end
        end

        default:
        begin
          state <= IDLE;
          cs_n  <= 1'b1;
          mosi  <= 1'b0;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    // tx_shift holds the bits still to go with the MSB next
    if (accept)
      tx_shift <= {cmd_bus.cmd[10:0], 1'b0};
    else if ((state == SHIFT_CMD) && fall)
      tx_shift <= {tx_shift[10:0], 1'b0};

    if ((state == SHIFT_READ) && rise)
      rx_shift <= {rx_shift[6:0], miso};
  end

endmodule

// ==== logic/spi_cmd_if.sv ====
interface spi_cmd_if;
  import spi_cmd_pkg::*;

  spi_cmd_t  cmd;
  logic      cmd_vld;
  logic      cmd_rdy;
  spi_data_t rd_data;
  logic      rd_vld;

  modport host (
    output cmd,
    output cmd_vld,
    input  cmd_rdy,
    input  rd_data,
    input  rd_vld
  );

  modport engine (
    input  cmd,
    input  cmd_vld,
    output cmd_rdy,
    output rd_data,
    output rd_vld
  );

endinterface

// ==== logic/spi_cmd_pkg.sv ====
package spi_cmd_pkg;

  // one frame command with the write flag in bit 11, the register in 10:8 and the data in 7:0
  typedef logic [11:0] spi_cmd_t;
  typedef logic [7:0]  spi_data_t;
  typedef logic [2:0]  spi_addr_t;

  // half-period of sclk in clk cycles where 0 behaves like 1
  typedef logic [7:0]  sclk_div_t;
  typedef logic [7:0]  apb_addr_t;

  typedef enum logic [2:0] {
    IDLE,
    SHIFT_CMD,
    GAP,
    SHIFT_READ,
    DONE
  } engine_state_t;

  localparam apb_addr_t REG_CMD    = 8'h00;
  localparam apb_addr_t REG_STATUS = 8'h04;
  localparam apb_addr_t REG_RDATA  = 8'h08;
  localparam apb_addr_t REG_DIV    = 8'h0C;

  // bit counts of the three kinds of chip-select window
  localparam int WRITE_BITS = 12;
  localparam int ADDR_BITS  = 4;
  localparam int READ_BITS  = 8;

endpackage

// ==== logic/spi_master_top.sv ====
module spi_master_top #(
  parameter int                     GAP_CLKS  = 16,
  parameter spi_cmd_pkg::sclk_div_t DIV_RESET = 8'd4
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  spi_cmd_pkg::apb_addr_t paddr,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [31:0]            pwdata,
  output logic [31:0]            prdata,
  output logic                   pready,
  output logic                   pslverr,
  output logic                   sclk,
  output logic                   cs_n,
  output logic                   mosi,
  input  logic                   miso
);
  import spi_cmd_pkg::*;

  sclk_div_t div;
  logic      run;
  logic      rise;
  logic      fall;

  spi_cmd_if cmd_bus ();

  spi_apb_regs #(
    .DIV_RESET (DIV_RESET)
  ) u_regs (
    .clk     (clk),
    .rst_n   (rst_n),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .cmd_bus (cmd_bus.host),
    .div     (div)
  );

  spi_sclk_gen u_sclk_gen (
    .clk   (clk),
    .rst_n (rst_n),
    .div   (div),
    .run   (run),
    .sclk  (sclk),
    .rise  (rise),
    .fall  (fall)
  );

  spi_cmd_engine #(
    .GAP_CLKS (GAP_CLKS)
  ) u_engine (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd_bus (cmd_bus.engine),
    .rise    (rise),
    .fall    (fall),
    .run     (run),
    .cs_n    (cs_n),
    .mosi    (mosi),
    .miso    (miso)
  );

endmodule

// ==== logic/spi_sclk_gen.sv ====
module spi_sclk_gen (
  input  logic                   clk,
  input  logic                   rst_n,
  input  spi_cmd_pkg::sclk_div_t div,
  input  logic                   run,
  output logic                   sclk,
  output logic                   rise,
  output logic                   fall
);
  import spi_cmd_pkg::*;

  sclk_div_t half;
  sclk_div_t cnt;
  logic      last;

  assign half = (div == '0) ? sclk_div_t'(1) : div;

  // the compare is open upwards so a smaller divider written mid-count
  // cannot make the counter run around
  assign last = run && (cnt >= half - 1'b1);

  // strobes mark the clk edge at which sclk toggles
  assign rise = last && !sclk;
  assign fall = last && sclk;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt  <= '0;
      sclk <= 1'b0;
    end
    else if (!run)
    begin
      // idle keeps sclk low and restarts the next burst with a full half-period
      cnt  <= '0;
      sclk <= 1'b0;
    end
    else if (last)
    begin
      cnt  <= '0;
      sclk <= !sclk;
    end
    else
    begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

// ==== verification/spi_dev_model.sv ====
module spi_dev_model (
  input  logic sclk,
  input  logic cs_n,
  input  logic mosi,
  output logic miso,
  output logic proto_err
);

  logic [7:0]  regs [8];
  logic [11:0] in_shift;
  logic [7:0]  out_bits;
  logic [2:0]  rd_addr;
  logic        rd_pending;
  logic        data_window;
  logic        in_window;
  int          bit_cnt;
  int          frame_cnt;

  initial
  begin
    for (int i = 0; i < 8; i++)
      regs[i] = 8'h00;
    miso        = 1'b0;
    proto_err   = 1'b0;
    in_shift    = '0;
    out_bits    = '0;
    rd_addr     = '0;
    rd_pending  = 1'b0;
    data_window = 1'b0;
    in_window   = 1'b0;
    bit_cnt     = 0;
    frame_cnt   = 0;
  end

  // a window opens, and a pending read gets its MSB ready before the first rise
  always @(negedge cs_n)
  begin
    in_window = 1'b1;
    bit_cnt   = 0;
    in_shift  = '0;
    if (rd_pending)
    begin
      data_window = 1'b1;
      out_bits    = regs[rd_addr];
      miso       <= out_bits[7];
    end
    else
    begin
      data_window = 1'b0;
    end
  end

  always @(posedge sclk)
  begin
    if (in_window && !cs_n)
    begin
      bit_cnt  = bit_cnt + 1;
      in_shift = {in_shift[10:0], mosi};
    end
  end

  always @(negedge sclk)
  begin
    if (data_window && !cs_n)
    begin
      out_bits = {out_bits[6:0], 1'b0};
      miso    <= out_bits[7];
    end
  end

  always @(posedge cs_n)
  begin
    if (in_window)
    begin
      in_window = 1'b0;
      frame_cnt = frame_cnt + 1;
      if (bit_cnt == 12 && in_shift[11] && !rd_pending)
      begin
        regs[in_shift[10:8]] = in_shift[7:0];
      end
      else if (bit_cnt == 4 && !in_shift[3] && !rd_pending)
      begin
        rd_pending = 1'b1;
        rd_addr    = in_shift[2:0];
      end
      else if (bit_cnt == 8 && data_window)
      begin
        rd_pending  = 1'b0;
        data_window = 1'b0;
      end
      else
      begin
        $display("SPI device saw a chip-select window of %0d bits that fits no frame at %0t",
                 bit_cnt, $time);
        proto_err = 1'b1;
      end
    end
  end

endmodule

// ==== verification/tb_spi_master.sv ====
module tb_spi_master;
  import spi_cmd_pkg::*;

  localparam int POLL_LIMIT = 4000;

  logic        clk;
  logic        rst_n;
  apb_addr_t   paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        sclk;
  logic        cs_n;
  logic        mosi;
  logic        miso;
  logic        proto_err;

  // mirror of the device registers
  logic [7:0] model [8];

  spi_master_top UUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .sclk    (sclk),
    .cs_n    (cs_n),
    .mosi    (mosi),
    .miso    (miso)
  );

  spi_dev_model dev (
    .sclk      (sclk),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .miso      (miso),
    .proto_err (proto_err)
  );

  always #4 clk = ~clk;

  always @(posedge proto_err)
  begin
    $display("=== FAIL ===");
    $fatal(1, "the SPI device received a malformed frame");
  end

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
      $display("=== FAIL ===");
      $fatal(1, "value mismatch");
    end
  endtask

  // setup phase, then access phase; responses are sampled mid-phase
  task automatic apb_write(input apb_addr_t addr, input logic [31:0] data, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    err = pslverr;
    check("write pready", pready, 1);
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_read(input apb_addr_t addr, output logic [31:0] data, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    data = prdata;
    err  = pslverr;
    check("read pready", pready, 1);
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic wait_idle();
    logic [31:0] st;
    logic        err;
    int          n;
    n = 0;
    st = 32'h1;
    while (st[0])
    begin
      apb_read(REG_STATUS, st, err);
      n++;
      if (n > POLL_LIMIT)
      begin
        $display("=== FAIL ===");
        $fatal(1, "busy flag never cleared");
      end
    end
  endtask

  // issues one command, waits for it, and checks read results against the mirror
  task automatic run_cmd(input logic wr, input logic [2:0] addr, input logic [7:0] data);
    logic [31:0] rd;
    logic        err;
    apb_write(REG_CMD, {20'd0, wr, addr, data}, err);
    check("CMD pslverr", err, 0);
    wait_idle();
    if (wr)
    begin
      model[addr] = data;
      apb_read(REG_STATUS, rd, err);
      check("STATUS after write", rd, 32'h0);
    end
    else
    begin
      apb_read(REG_STATUS, rd, err);
      check("STATUS after read", rd, 32'h2);
      apb_read(REG_RDATA, rd, err);
      check("RDATA", rd, {24'd0, model[addr]});
      apb_read(REG_STATUS, rd, err);
      check("STATUS after RDATA read", rd, 32'h0);
    end
  endtask

  initial
  begin
    logic [31:0] rd;
    logic        err;
    logic [7:0]  d;
    int          frames;
    clk     = 1'b0;
    rst_n   = 1'b0;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    void'($urandom(32'h193c_b598));
    for (int i = 0; i < 8; i++)
      model[i] = 8'h00;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    apb_read(REG_STATUS, rd, err);
    check("reset STATUS", rd, 32'h0);
    check("reset pslverr", err, 0);
    apb_read(REG_DIV, rd, err);
    check("reset DIV", rd, 32'd4);
    apb_read(REG_RDATA, rd, err);
    check("reset RDATA", rd, 32'h0);
    check("reset cs_n", cs_n, 1);
    check("reset sclk", sclk, 0);

    for (int a = 0; a < 8; a++)
    begin
      run_cmd(1'b1, 3'(a), 8'($urandom));
      run_cmd(1'b0, 3'(a), 8'h00);
    end

    for (int b = 0; b < 8; b++)
    begin
      apb_write(REG_DIV, $urandom_range(6, 0), err);
      for (int k = 0; k < 25; k++)
        run_cmd(1'($urandom), 3'($urandom), 8'($urandom));
    end

    // a second CMD write during a frame is refused
    apb_write(REG_DIV, 32'd3, err);
    frames = dev.frame_cnt;
    d = 8'($urandom);
    apb_write(REG_CMD, {20'd0, 1'b1, 3'd2, d}, err);
    check("first CMD pslverr", err, 0);
    apb_write(REG_CMD, {20'd0, 1'b1, 3'd5, ~model[5]}, err);
    check("refused CMD pslverr", err, 1);
    wait_idle();
    model[2] = d;
    check("frames after refusal", dev.frame_cnt, frames + 1);
    run_cmd(1'b0, 3'd5, 8'h00);
    run_cmd(1'b0, 3'd2, 8'h00);

    // rd_valid is sticky across STATUS reads
    run_cmd(1'b1, 3'd7, 8'h5a);
    apb_write(REG_CMD, {20'd0, 1'b0, 3'd7, 8'h00}, err);
    wait_idle();
    apb_read(REG_STATUS, rd, err);
    check("sticky STATUS 1", rd, 32'h2);
    apb_read(REG_STATUS, rd, err);
    check("sticky STATUS 2", rd, 32'h2);
    apb_read(REG_RDATA, rd, err);
    check("sticky RDATA", rd, 32'h5a);
    apb_read(REG_STATUS, rd, err);
    check("STATUS cleared", rd, 32'h0);

    $display("=== PASS ===");
    $finish;
  end

endmodule
